// ==== fetch_frontend.f ====
src/frontend_pkg.sv
src/apb_pkg.sv
src/fetch_if.sv
src/inst_mem.sv
src/fetch_unit.sv
src/branch_predecoder.sv
src/inst_buffer.sv
src/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the front-end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
    -f fetch_frontend.f \
    --top-module tb_fetch_frontend \
    -o sim_fetch_frontend

./obj_dir/sim_fetch_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
exit 0

// ==== src/apb_pkg.sv ====
package apb_pkg;

    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    // Instruction memory window, 1 KiB
    // Unaligned or out-of-window accesses return a slave error
    localparam int IMEM_BYTES = 1024;

endpackage

// ==== src/branch_predecoder.sv ====
module branch_predecoder
    import frontend_pkg::*;
(
    fetch_if.pred fetch
);

    logic            is_cond;
    logic            is_jal;
    logic            taken;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;

    // B-type and J-type immediates, bit 0 always zero
    assign imm_b = {{19{fetch.inst[31]}}, fetch.inst[31], fetch.inst[7],
                    fetch.inst[30:25], fetch.inst[11:8], 1'b0};
    assign imm_j = {{11{fetch.inst[31]}}, fetch.inst[31], fetch.inst[19:12],
                    fetch.inst[20], fetch.inst[30:21], 1'b0};

    assign is_cond = (fetch.inst[6:0] == OPC_BRANCH);
    assign is_jal  = (fetch.inst[6:0] == OPC_JAL);
    assign imm     = is_jal ? imm_j : imm_b;

    // Static rule, JAL always and backward branches taken
    assign taken = is_jal | (is_cond & imm_b[XLEN-1]);

    assign fetch.is_branch   = is_cond | is_jal;
    assign fetch.pred_taken  = taken;
    assign fetch.pred_target = taken ? fetch.pc + imm : fetch.pc + XLEN'(4);

endmodule

// ==== src/fetch_frontend.sv ====
module fetch_frontend
    import frontend_pkg::*;
    import apb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  fetch_en_i,
    input  logic                  redirect_i,
    input  logic [XLEN-1:0]       redirect_pc_i,
    input  logic [1:0]            issue_take_i,
    output logic                  slot0_valid_o,
    output logic [XLEN-1:0]       slot0_inst_o,
    output logic [XLEN-1:0]       slot0_pc_o,
    output logic                  slot0_is_branch_o,
    output logic                  slot0_pred_taken_o,
    output logic [XLEN-1:0]       slot0_pred_target_o,
    output logic                  slot1_valid_o,
    output logic [XLEN-1:0]       slot1_inst_o,
    output logic [XLEN-1:0]       slot1_pc_o,
    output logic                  slot1_is_branch_o,
    output logic                  slot1_pred_taken_o,
    output logic [XLEN-1:0]       slot1_pred_target_o
);

    logic                  req_valid;
    logic [XLEN-1:0]       req_pc;
    logic                  drop;
    logic [IBUF_CNT_W-1:0] free_count;
    issue_slot_t           slot0;
    issue_slot_t           slot1;

    fetch_if fetch ();

    fetch_unit u_fetch_unit (
        .clk, .rst_n_i, .fetch_en_i, .redirect_i, .redirect_pc_i,
        .free_count_i(free_count), .req_valid_o(req_valid), .req_pc_o(req_pc),
        .in_flight_drop_o(drop)
    );

    inst_mem u_inst_mem (
        .clk, .rst_n_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .req_valid_i(req_valid), .req_pc_i(req_pc), .fetch(fetch.mem)
    );

    branch_predecoder u_predecoder (.fetch(fetch.pred));

    // Redirect flushes the queue at the same edge the PC reloads
    inst_buffer u_inst_buffer (
        .clk, .rst_n_i, .flush_i(redirect_i), .drop_i(drop), .fetch(fetch.ibuf),
        .issue_take_i, .slot0_o(slot0), .slot1_o(slot1), .free_count_o(free_count)
    );

    // Unpack issue slots
    assign slot0_valid_o       = slot0.valid;
    assign slot0_inst_o        = slot0.entry.inst;
    assign slot0_pc_o          = slot0.entry.pc;
    assign slot0_is_branch_o   = slot0.entry.is_branch;
    assign slot0_pred_taken_o  = slot0.entry.pred_taken;
    assign slot0_pred_target_o = slot0.entry.pred_target;
    assign slot1_valid_o       = slot1.valid;
    assign slot1_inst_o        = slot1.entry.inst;
    assign slot1_pc_o          = slot1.entry.pc;
    assign slot1_is_branch_o   = slot1.entry.is_branch;
    assign slot1_pred_taken_o  = slot1.entry.pred_taken;
    assign slot1_pred_target_o = slot1.entry.pred_target;

endmodule

// ==== src/fetch_if.sv ====
interface fetch_if
    import frontend_pkg::*;
();

    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic            is_branch;
    logic            pred_taken;
    logic [XLEN-1:0] pred_target;

    // Memory side returns the raw word
    modport mem (output valid, pc, inst);

    // Predecoder adds the branch info
    modport pred (input inst, pc, output is_branch, pred_taken, pred_target);

    // Instruction buffer sees the whole entry
    modport ibuf (input valid, pc, inst, is_branch, pred_taken, pred_target);

endinterface

// ==== src/fetch_unit.sv ====
module fetch_unit
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  fetch_en_i,
    input  logic                  redirect_i,
    input  logic [XLEN-1:0]       redirect_pc_i,
    input  logic [IBUF_CNT_W-1:0] free_count_i,
    output logic                  req_valid_o,
    output logic [XLEN-1:0]       req_pc_o,
    output logic                  in_flight_drop_o
);

    logic [XLEN-1:0] pc_q;
    logic            in_flight_q;
    logic            drop_q;

    // Credit check
    // The word sitting in the memory output register still needs a slot,
    // so it is subtracted from the free count before a new request
    assign req_valid_o = fetch_en_i && (free_count_i > IBUF_CNT_W'(in_flight_q));
    assign req_pc_o    = pc_q;

    assign in_flight_drop_o = drop_q;

    //////////////////////////////
    // PC and in-flight tracking
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q        <= RESET_PC;
            in_flight_q <= 1'b0;
            drop_q      <= 1'b0;
        end else begin
            in_flight_q <= req_valid_o;
            // Request issued in the redirect cycle carries the old path
            drop_q      <= redirect_i & req_valid_o;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (req_valid_o) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

endmodule

// ==== src/frontend_pkg.sv ====
package frontend_pkg;

    //////////////////////////////
    // ISA widths and opcodes
    //////////////////////////////
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    //////////////////////////////
    // Front-end sizing
    //////////////////////////////
    localparam int IBUF_DEPTH = 16;
    localparam int IBUF_PTR_W = 4;
    // One extra bit so a full buffer can be counted
    localparam int IBUF_CNT_W = IBUF_PTR_W + 1;

    // Fetch index is PC[9:2], wraps at the end of memory
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);

    // One queued instruction with its static prediction
    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic            is_branch;
        logic            pred_taken;
        logic [XLEN-1:0] pred_target;
    } fetch_entry_t;

    typedef struct packed {
        logic         valid;
        fetch_entry_t entry;
    } issue_slot_t;

endpackage

// ==== src/inst_buffer.sv ====
module inst_buffer
    import frontend_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  drop_i,
    fetch_if.ibuf                 fetch,
    input  logic [1:0]            issue_take_i,
    output issue_slot_t           slot0_o,
    output issue_slot_t           slot1_o,
    output logic [IBUF_CNT_W-1:0] free_count_o
);

    fetch_entry_t            mem_q [IBUF_DEPTH];
    logic [IBUF_PTR_W-1:0]   head_q;
    logic [IBUF_PTR_W-1:0]   tail_q;
    logic [IBUF_PTR_W-1:0]   head_next;
    logic [IBUF_CNT_W-1:0]   count_q;
    logic                    wr_en;
    logic [1:0]              pop_cnt;
    fetch_entry_t            wr_entry;

    //////////////////////////////
    // Write side
    //////////////////////////////
    always_comb begin
        wr_entry.inst        = fetch.inst;
        wr_entry.pc          = fetch.pc;
        wr_entry.is_branch   = fetch.is_branch;
        wr_entry.pred_taken  = fetch.pred_taken;
        wr_entry.pred_target = fetch.pred_target;
    end

    // No ready needed, the fetch unit only asks when there is room
    assign wr_en = fetch.valid & ~drop_i;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[tail_q] <= wr_entry;
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////
    // Never retire more than are held
    always_comb begin
        if (IBUF_CNT_W'(issue_take_i) > count_q) begin
            pop_cnt = count_q[1:0];
        end else begin
            pop_cnt = issue_take_i;
        end
    end

    assign head_next = head_q + IBUF_PTR_W'(1);

    // Two oldest entries, shown combinationally
    assign slot0_o.valid = (count_q != '0);
    assign slot0_o.entry = mem_q[head_q];
    assign slot1_o.valid = (count_q >= IBUF_CNT_W'(2));
    assign slot1_o.entry = mem_q[head_next];

    assign free_count_o = IBUF_CNT_W'(IBUF_DEPTH) - count_q;

    //////////////////////////////
    // Pointers and occupancy
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + IBUF_PTR_W'(pop_cnt);
            tail_q  <= tail_q + IBUF_PTR_W'(wr_en);
            count_q <= count_q + IBUF_CNT_W'(wr_en) - IBUF_CNT_W'(pop_cnt);
        end
    end

endmodule

// ==== src/inst_mem.sv ====
module inst_mem
    import frontend_pkg::*;
    import apb_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  req_valid_i,
    input  logic [XLEN-1:0]       req_pc_i,
    fetch_if.mem                  fetch
);

    logic [XLEN-1:0]    mem [IMEM_WORDS];
    logic               apb_access;
    logic               apb_err;
    logic [IMEM_AW-1:0] apb_idx;
    logic [IMEM_AW-1:0] fetch_idx;
    logic               valid_q;
    logic [XLEN-1:0]    pc_q;
    logic [XLEN-1:0]    inst_q;

    //////////////////////////////
    // APB port, zero wait states
    //////////////////////////////
    assign apb_access = psel_i & penable_i;
    assign apb_err    = (paddr_i >= APB_ADDR_W'(IMEM_BYTES)) | (paddr_i[1:0] != 2'b00);
    assign apb_idx    = paddr_i[IMEM_AW+1:2];

    assign pready_o  = apb_access;
    assign pslverr_o = apb_access & apb_err;
    assign prdata_o  = (apb_access && !pwrite_i && !apb_err) ? mem[apb_idx] : '0;

    always_ff @(posedge clk) begin
        if (apb_access && pwrite_i && !apb_err) begin
            mem[apb_idx] <= pwdata_i;
        end
    end

    //////////////////////////////
    // Fetch port, one cycle read
    //////////////////////////////
    assign fetch_idx = req_pc_i[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        inst_q <= mem[fetch_idx];
        pc_q   <= req_pc_i;
    end

    // Stale returns after a redirect are dropped downstream
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
        end
    end

    assign fetch.valid = valid_q;
    assign fetch.pc    = pc_q;
    assign fetch.inst  = inst_q;

endmodule

// ==== testbench/tb_fetch_frontend.sv ====
module tb_fetch_frontend
    import frontend_pkg::*;
    import apb_pkg::*;
();

    logic                  clk;
    logic                  rst_n_i;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  fetch_en;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;
    logic [1:0]            take;
    logic                  s0_valid;
    logic                  s0_br;
    logic                  s0_tk;
    logic                  s1_valid;
    logic                  s1_br;
    logic                  s1_tk;
    logic [XLEN-1:0]       s0_inst;
    logic [XLEN-1:0]       s0_pc;
    logic [XLEN-1:0]       s0_tgt;
    logic [XLEN-1:0]       s1_inst;
    logic [XLEN-1:0]       s1_pc;
    logic [XLEN-1:0]       s1_tgt;

    logic [XLEN-1:0] image [IMEM_WORDS];
    logic [XLEN-1:0] exp_pc = RESET_PC;
    logic            checking;
    int              issued = 0;

    fetch_frontend DUT (
        .clk, .rst_n_i, .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
        .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
        .pslverr_o(pslverr), .fetch_en_i(fetch_en), .redirect_i(redirect),
        .redirect_pc_i(redirect_pc), .issue_take_i(take),
        .slot0_valid_o(s0_valid), .slot0_inst_o(s0_inst), .slot0_pc_o(s0_pc),
        .slot0_is_branch_o(s0_br), .slot0_pred_taken_o(s0_tk), .slot0_pred_target_o(s0_tgt),
        .slot1_valid_o(s1_valid), .slot1_inst_o(s1_inst), .slot1_pc_o(s1_pc),
        .slot1_is_branch_o(s1_br), .slot1_pred_taken_o(s1_tk), .slot1_pred_target_o(s1_tgt)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Expected entry from the RV32I encoding rules
    function automatic fetch_entry_t predecode_ref(input logic [31:0] inst,
                                                   input logic [31:0] pc);
        fetch_entry_t e;
        logic [31:0]  imm;
        logic         br;
        logic         jal;
        logic         tk;
        br  = (inst[6:0] == OPC_BRANCH);
        jal = (inst[6:0] == OPC_JAL);
        if (jal) begin
            imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end else begin
            imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        tk = jal | (br & inst[31]);
        e.inst        = inst;
        e.pc          = pc;
        e.is_branch   = br | jal;
        e.pred_taken  = tk;
        e.pred_target = tk ? pc + imm : pc + 32'd4;
        return e;
    endfunction

    task automatic check_slot(input string name, input fetch_entry_t got,
                              input fetch_entry_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_apb_word(input string name, input logic [APB_DATA_W-1:0] got,
                                  input logic [APB_DATA_W-1:0] exp);
        if (got !== exp) fail_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_slverr(input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("ERROR pslverr_o got %h expected %h", got, exp));
    endtask

    // Setup phase then access phase, sampled mid access phase
    task automatic apb_xfer(input logic [APB_ADDR_W-1:0] a, input logic wr,
                            input logic [APB_DATA_W-1:0] wd, output logic [APB_DATA_W-1:0] rd,
                            output logic err);
        @(negedge clk);
        paddr   = a;
        pwrite  = wr;
        pwdata  = wd;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #5;
        if (pready !== 1'b1) fail_run("APB access phase did not see pready high");
        rd  = prdata;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Random take counts, never more than the valid slots
    task automatic run_random(input int count);
        int   target;
        int   guard;
        logic [1:0] n;
        logic [1:0] r;
        target = issued + count;
        guard  = 0;
        while (issued < target) begin
            @(negedge clk);
            n    = 2'(s0_valid) + 2'(s1_valid);
            r    = 2'($urandom % 3);
            take = (r > n) ? n : r;
            guard++;
            if (guard > count * 20 + 100) fail_run("Timeout waiting for entries to issue");
        end
        @(negedge clk);
        take = 2'd0;
    endtask

    ////////////////////////////////
    // Compare process
    ////////////////////////////////
    always @(posedge clk) begin
        if (rst_n_i && checking) begin
            if (s1_valid && !s0_valid) fail_run("Slot 1 valid while slot 0 is empty");
            if (redirect) begin
                exp_pc = redirect_pc;
            end else begin
                if (take >= 2'd1) begin
                    check_slot("slot0", {s0_inst, s0_pc, s0_br, s0_tk, s0_tgt},
                               predecode_ref(image[exp_pc[9:2]], exp_pc));
                    exp_pc = exp_pc + 32'd4;
                    issued++;
                end
                if (take == 2'd2) begin
                    check_slot("slot1", {s1_inst, s1_pc, s1_br, s1_tk, s1_tgt},
                               predecode_ref(image[exp_pc[9:2]], exp_pc));
                    exp_pc = exp_pc + 32'd4;
                    issued++;
                end
            end
        end
    end

    initial begin
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        int                    start;
        int                    guard;
        void'($urandom(32'h9f8c_f951));
        clk         = 0;
        rst_n_i     = 0;
        paddr       = '0;
        psel        = 0;
        penable     = 0;
        pwrite      = 0;
        pwdata      = '0;
        fetch_en    = 0;
        redirect    = 0;
        redirect_pc = '0;
        take        = 2'd0;
        checking    = 0;
        // Mix of branches, JALs and other words
        for (int i = 0; i < IMEM_WORDS; i++) begin
            case ($urandom % 4)
                0: image[i] = {25'($urandom), OPC_BRANCH};
                1: image[i] = {25'($urandom), OPC_JAL};
                default: image[i] = $urandom;
            endcase
        end
        repeat (8) @(negedge clk);
        rst_n_i = 1;
        if (s0_valid || s1_valid) fail_run("Slot valid high after reset");

        //////////////////////////////
        // Memory load over APB
        //////////////////////////////
        for (int i = 0; i < IMEM_WORDS; i++) begin
            apb_xfer(APB_ADDR_W'(i * 4), 1'b1, image[i], rd, err);
            check_slverr(err, 1'b0);
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin
            apb_xfer(APB_ADDR_W'(i * 4), 1'b0, '0, rd, err);
            check_slverr(err, 1'b0);
            check_apb_word("prdata_o", rd, image[i]);
        end
        apb_xfer(12'h400, 1'b1, 32'hdead_beef, rd, err);
        check_slverr(err, 1'b1);
        apb_xfer(12'h002, 1'b0, '0, rd, err);
        check_slverr(err, 1'b1);
        apb_xfer(12'h000, 1'b0, '0, rd, err);
        check_apb_word("prdata_o", rd, image[0]);

        // Sequential fetch with random back-pressure
        checking = 1;
        fetch_en = 1;
        run_random(300);

        // Buffer fills and stops at its depth
        repeat (IBUF_DEPTH + 24) @(negedge clk);
        if (!s0_valid || !s1_valid) fail_run("Full buffer does not show two valid slots");
        fetch_en = 0;
        start    = issued;
        guard    = 0;
        while (s0_valid) begin
            take = 2'(s0_valid) + 2'(s1_valid);
            @(negedge clk);
            guard++;
            if (guard > 100) fail_run("Timeout draining the full buffer");
        end
        take = 2'd0;
        if (issued - start != IBUF_DEPTH) begin
            fail_run($sformatf("ERROR drained count got %h expected %h",
                               issued - start, IBUF_DEPTH));
        end

        // Redirect into a new PC and continue
        fetch_en = 1;
        run_random(20);
        @(negedge clk);
        redirect    = 1;
        redirect_pc = 32'h0000_0208;
        @(negedge clk);
        redirect = 0;
        run_random(60);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
